// ==== source/matrix_log_settings.svh ====
`ifndef MATRIX_LOG_SETTINGS_SVH
`define MATRIX_LOG_SETTINGS_SVH

// Element width, unsigned
`define MLOG_DATA_W 16

// Result is 5 integer bits over 8 fraction bits
`define MLOG_RES_W 13
`define MLOG_FRAC_W 8

// Row and column count width
`define MLOG_SIZE_W 8

// Output credits per channel after reset
`define MLOG_CREDITS 4

`endif

// ==== source/matrix_log_pkg.sv ====
package matrix_log_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Channel FSM
  ////////////////////////////////////////////////////////////////////////////

  // Wait for start, take element, request core, wait result, send it out
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    INPUT = 3'd1,
    ISSUE = 3'd2,
    WAIT  = 3'd3,
    EMIT  = 3'd4
  } chan_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Shared core
  ////////////////////////////////////////////////////////////////////////////

  // Owner of an operand travelling through the log2 pipeline
  typedef enum logic {
    TAG_A = 1'b0,
    TAG_B = 1'b1
  } core_tag_t;

endpackage

// ==== source/log2_core.sv ====
`timescale 1ns/1ps
`include "matrix_log_settings.svh"

module log2_core (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      in_valid,
  input  logic [`MLOG_DATA_W-1:0]   in_data,
  input  matrix_log_pkg::core_tag_t in_tag,
  output logic                      out_valid,
  output logic [`MLOG_RES_W-1:0]    out_data,
  output matrix_log_pkg::core_tag_t out_tag
);
  import matrix_log_pkg::*;

  // Leading-one index width and integer part width of the result
  localparam int POS_W = $clog2(`MLOG_DATA_W);
  localparam int INT_W = `MLOG_RES_W - `MLOG_FRAC_W;

  // Stage one
  logic [POS_W-1:0]        lead_pos;
  logic                    s1_valid;
  logic [`MLOG_DATA_W-1:0] s1_data;
  logic [POS_W-1:0]        s1_pos;
  core_tag_t               s1_tag;

  // Stage two
  logic [POS_W-1:0]        shift_amt;
  logic [`MLOG_DATA_W-1:0] aligned;
  logic [`MLOG_FRAC_W-1:0] frac;

  // Priority search where the highest set bit wins
  // Zero input leaves position 0
  always_comb begin
    lead_pos = '0;
    for (int k = 0; k < `MLOG_DATA_W; k++) begin
      if (in_data[k]) begin
        lead_pos = POS_W'(k);
      end
    end
  end

  // Move the leading one to the MSB so the bits under it form the fraction
  // Short inputs get zeros shifted in on the right
  always_comb begin
    shift_amt = POS_W'(`MLOG_DATA_W - 1) - s1_pos;
    aligned   = s1_data << shift_amt;
    frac      = aligned[`MLOG_DATA_W-2 -: `MLOG_FRAC_W];
  end

  // Valid pipe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  // Data pipe loads only on a live item
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      s1_data <= in_data;
      s1_pos  <= lead_pos;
      s1_tag  <= in_tag;
    end
    if (s1_valid) begin
      out_data <= {INT_W'(s1_pos), frac};
      out_tag  <= s1_tag;
    end
  end

  // Result two cycles after the operand
  // Integer part is the leading-one position, zero maps to zero
  a_result : assert property (@(posedge CLK) disable iff (RST)
    in_valid |-> ##2 (out_valid &&
      (($past(in_data, 2) == '0) ? (out_data == '0) :
        (($past(in_data, 2) >> out_data[`MLOG_RES_W-1 -: INT_W]) == 1))));

endmodule

// ==== source/core_arbiter.sv ====
`timescale 1ns/1ps
`include "matrix_log_settings.svh"

module core_arbiter (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      req_a,
  input  logic                      req_b,
  input  logic [`MLOG_DATA_W-1:0]   req_data_a,
  input  logic [`MLOG_DATA_W-1:0]   req_data_b,
  output logic                      grant_a,
  output logic                      grant_b,
  output logic                      core_valid,
  output logic [`MLOG_DATA_W-1:0]   core_data,
  output matrix_log_pkg::core_tag_t core_tag,
  input  logic                      core_out_valid,
  input  logic [`MLOG_RES_W-1:0]    core_out_data,
  input  matrix_log_pkg::core_tag_t core_out_tag,
  output logic                      resp_valid_a,
  output logic                      resp_valid_b,
  output logic [`MLOG_RES_W-1:0]    resp_data
);
  import matrix_log_pkg::*;

  // Set when channel B held the core last
  logic last_b;

  // Lone request always wins
  // On a tie the channel that waited goes first
  assign grant_a = req_a && (!req_b || last_b);
  assign grant_b = req_b && (!req_a || !last_b);

  // Operand mux toward the core
  assign core_valid = grant_a || grant_b;
  assign core_data  = grant_b ? req_data_b : req_data_a;
  assign core_tag   = grant_b ? TAG_B : TAG_A;

  // Return path by tag with one data bus for both channels
  assign resp_valid_a = core_out_valid && (core_out_tag == TAG_A);
  assign resp_valid_b = core_out_valid && (core_out_tag == TAG_B);
  assign resp_data    = core_out_data;

  // Round-robin pointer
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      last_b <= 1'b0;
    end else if (core_valid) begin
      last_b <= grant_b;
    end
  end

  // Each grant comes back to its own channel after the two core stages
  a_route_a : assert property (@(posedge CLK) disable iff (RST)
    grant_a |-> ##2 resp_valid_a);

  a_route_b : assert property (@(posedge CLK) disable iff (RST)
    grant_b |-> ##2 resp_valid_b);

endmodule

// ==== source/matrix_log_channel.sv ====
`timescale 1ns/1ps
`include "matrix_log_settings.svh"

module matrix_log_channel (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  output logic                    ready,
  input  logic [`MLOG_SIZE_W-1:0] size_i,
  input  logic [`MLOG_SIZE_W-1:0] size_j,
  input  logic [`MLOG_DATA_W-1:0] data_in,
  input  logic                    data_in_enable,
  output logic                    in_ready,
  output logic                    req,
  output logic [`MLOG_DATA_W-1:0] req_data,
  input  logic                    grant,
  input  logic                    resp_valid,
  input  logic [`MLOG_RES_W-1:0]  resp_data,
  output logic [`MLOG_RES_W-1:0]  data_out,
  output logic                    out_enable,
  output logic                    row_end,
  output logic                    matrix_end,
  input  logic                    credit_return
);
  import matrix_log_pkg::*;

  localparam int SIZE_W = `MLOG_SIZE_W;
  localparam int CRED_W = $clog2(`MLOG_CREDITS + 1);

  //////////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////////

  chan_state_t state;

  // Matrix walk
  logic [SIZE_W-1:0] idx_i;
  logic [SIZE_W-1:0] idx_j;
  logic [SIZE_W-1:0] size_i_q;
  logic [SIZE_W-1:0] size_j_q;
  logic              last_col;
  logic              last_row;

  // Element in flight
  logic [`MLOG_DATA_W-1:0] operand;
  logic [`MLOG_RES_W-1:0]  result;
  logic                    res_held;

  // Output credits
  logic [CRED_W-1:0] credits;

  //////////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////////

  assign last_col = (idx_j == size_j_q - SIZE_W'(1));
  assign last_row = (idx_i == size_i_q - SIZE_W'(1));

  assign in_ready = (state == INPUT);
  assign req      = (state == ISSUE);
  assign req_data = operand;

  // One result per EMIT cycle with its position markers
  assign out_enable = (state == EMIT);
  assign data_out   = result;
  assign row_end    = out_enable && last_col;
  assign matrix_end = out_enable && last_col && last_row;
  assign ready      = matrix_end;

  //////////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      idx_i    <= '0;
      idx_j    <= '0;
      res_held <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            idx_i <= '0;
            idx_j <= '0;
            state <= INPUT;
          end
        end
        INPUT: begin
          if (data_in_enable) begin
            state <= ISSUE;
          end
        end
        // Hold the request until the arbiter picks this channel
        ISSUE: begin
          if (grant) begin
            state <= WAIT;
          end
        end
        // Result parks here while no credit is left
        WAIT: begin
          if (resp_valid) begin
            res_held <= 1'b1;
          end
          if (res_held && (credits != '0)) begin
            res_held <= 1'b0;
            state    <= EMIT;
          end
        end
        // Row-major step, columns first
        EMIT: begin
          if (last_col && last_row) begin
            state <= IDLE;
          end else if (last_col) begin
            idx_i <= idx_i + SIZE_W'(1);
            idx_j <= '0;
            state <= INPUT;
          end else begin
            idx_j <= idx_j + SIZE_W'(1);
            state <= INPUT;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Dimensions, operand and result registers
  always_ff @(posedge CLK) begin
    if ((state == IDLE) && start) begin
      size_i_q <= size_i;
      size_j_q <= size_j;
    end
    if (in_ready && data_in_enable) begin
      operand <= data_in;
    end
    if ((state == WAIT) && resp_valid) begin
      result <= resp_data;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Credits
  //////////////////////////////////////////////////////////////////////////

  // Spend and return in the same cycle cancel out
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits <= CRED_W'(`MLOG_CREDITS);
    end else if (out_enable && !credit_return) begin
      credits <= credits - CRED_W'(1);
    end else if (credit_return && !out_enable) begin
      credits <= credits + CRED_W'(1);
    end
  end

  // Consumer may never hand back more than it was given
  a_credit_max : assert property (@(posedge CLK) disable iff (RST)
    credits <= CRED_W'(`MLOG_CREDITS));

  a_credit_emit : assert property (@(posedge CLK) disable iff (RST)
    out_enable |-> (credits != '0));

endmodule

// ==== source/matrix_log_top.sv ====
`timescale 1ns/1ps
`include "matrix_log_settings.svh"

module matrix_log_top (
  input  logic                    CLK,
  input  logic                    RST,

  // Channel A
  input  logic                    start_a,
  output logic                    ready_a,
  input  logic [`MLOG_SIZE_W-1:0] size_i_a,
  input  logic [`MLOG_SIZE_W-1:0] size_j_a,
  input  logic [`MLOG_DATA_W-1:0] data_in_a,
  input  logic                    data_in_enable_a,
  output logic                    in_ready_a,
  output logic [`MLOG_RES_W-1:0]  data_out_a,
  output logic                    out_enable_a,
  output logic                    row_end_a,
  output logic                    matrix_end_a,
  input  logic                    credit_return_a,

  // Channel B
  input  logic                    start_b,
  output logic                    ready_b,
  input  logic [`MLOG_SIZE_W-1:0] size_i_b,
  input  logic [`MLOG_SIZE_W-1:0] size_j_b,
  input  logic [`MLOG_DATA_W-1:0] data_in_b,
  input  logic                    data_in_enable_b,
  output logic                    in_ready_b,
  output logic [`MLOG_RES_W-1:0]  data_out_b,
  output logic                    out_enable_b,
  output logic                    row_end_b,
  output logic                    matrix_end_b,
  input  logic                    credit_return_b
);
  import matrix_log_pkg::*;

  // Channel side of the arbiter
  logic                    req_a;
  logic                    req_b;
  logic [`MLOG_DATA_W-1:0] req_data_a;
  logic [`MLOG_DATA_W-1:0] req_data_b;
  logic                    grant_a;
  logic                    grant_b;
  logic                    resp_valid_a;
  logic                    resp_valid_b;
  logic [`MLOG_RES_W-1:0]  resp_data;

  // Core side of the arbiter
  logic                    core_valid;
  logic [`MLOG_DATA_W-1:0] core_data;
  core_tag_t               core_tag;
  logic                    core_out_valid;
  logic [`MLOG_RES_W-1:0]  core_out_data;
  core_tag_t               core_out_tag;

  matrix_log_channel channel_a (
    .CLK(CLK), .RST(RST),
    .start(start_a), .ready(ready_a),
    .size_i(size_i_a), .size_j(size_j_a),
    .data_in(data_in_a), .data_in_enable(data_in_enable_a), .in_ready(in_ready_a),
    .req(req_a), .req_data(req_data_a), .grant(grant_a),
    .resp_valid(resp_valid_a), .resp_data(resp_data),
    .data_out(data_out_a), .out_enable(out_enable_a),
    .row_end(row_end_a), .matrix_end(matrix_end_a),
    .credit_return(credit_return_a)
  );

  matrix_log_channel channel_b (
    .CLK(CLK), .RST(RST),
    .start(start_b), .ready(ready_b),
    .size_i(size_i_b), .size_j(size_j_b),
    .data_in(data_in_b), .data_in_enable(data_in_enable_b), .in_ready(in_ready_b),
    .req(req_b), .req_data(req_data_b), .grant(grant_b),
    .resp_valid(resp_valid_b), .resp_data(resp_data),
    .data_out(data_out_b), .out_enable(out_enable_b),
    .row_end(row_end_b), .matrix_end(matrix_end_b),
    .credit_return(credit_return_b)
  );

  // Single log2 pipeline shared by both channels
  core_arbiter arbiter (
    .CLK(CLK), .RST(RST),
    .req_a(req_a), .req_b(req_b),
    .req_data_a(req_data_a), .req_data_b(req_data_b),
    .grant_a(grant_a), .grant_b(grant_b),
    .core_valid(core_valid), .core_data(core_data), .core_tag(core_tag),
    .core_out_valid(core_out_valid), .core_out_data(core_out_data),
    .core_out_tag(core_out_tag),
    .resp_valid_a(resp_valid_a), .resp_valid_b(resp_valid_b),
    .resp_data(resp_data)
  );

  log2_core core (
    .CLK(CLK), .RST(RST),
    .in_valid(core_valid), .in_data(core_data), .in_tag(core_tag),
    .out_valid(core_out_valid), .out_data(core_out_data), .out_tag(core_out_tag)
  );

endmodule

// ==== bench/matrix_log_table.svh ====
`ifndef MATRIX_LOG_TABLE_SVH
`define MATRIX_LOG_TABLE_SVH

// One matrix per table row, elements in row-major order, unused slots zero
// Row columns: channel (0 is A, 1 is B), row count, column count, credit hold
localparam int TBL_ROWS  = 6;
localparam int TBL_ELEMS = 12;

localparam int TBL_CHAN   [TBL_ROWS] = '{0, 1, 0, 1, 0, 1};
localparam int TBL_SIZE_I [TBL_ROWS] = '{2, 3, 1, 1, 2, 2};
localparam int TBL_SIZE_J [TBL_ROWS] = '{3, 4, 1, 5, 4, 2};
localparam bit TBL_HOLD   [TBL_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

// Element values
localparam logic [`MLOG_DATA_W-1:0] TBL_DATA [TBL_ROWS][TBL_ELEMS] = '{
  // Powers of two
  '{16'h0001, 16'h0002, 16'h0080, 16'h0100, 16'h4000, 16'h8000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  // All ones, zero and values in between
  '{16'hFFFF, 16'h0000, 16'h0003, 16'h0005, 16'h00FF, 16'h0181,
    16'h1234, 16'hABCD, 16'h0007, 16'h7FFF, 16'h0300, 16'h00A5},
  // Single element
  '{16'h0010, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  // One row
  '{16'h0000, 16'h0001, 16'h0008, 16'h2000, 16'hFFFE, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  // Run with credits withheld
  '{16'h0009, 16'h0011, 16'h00C0, 16'h0404, 16'h1001, 16'h3000,
    16'h5555, 16'h0FF0, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  '{16'h0002, 16'h0006, 16'h0F00, 16'h8001, 16'h0000, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
};

// Expected log2, integer part in the upper 5 bits, 8 fraction bits below
localparam logic [`MLOG_RES_W-1:0] TBL_EXP [TBL_ROWS][TBL_ELEMS] = '{
  '{13'h0000, 13'h0100, 13'h0700, 13'h0800, 13'h0E00, 13'h0F00,
    13'h0000, 13'h0000, 13'h0000, 13'h0000, 13'h0000, 13'h0000},
  '{13'h0FFF, 13'h0000, 13'h0180, 13'h0240, 13'h07FE, 13'h0881,
    13'h0C23, 13'h0F57, 13'h02C0, 13'h0EFF, 13'h0980, 13'h074A},
  '{13'h0400, 13'h0000, 13'h0000, 13'h0000, 13'h0000, 13'h0000,
    13'h0000, 13'h0000, 13'h0000, 13'h0000, 13'h0000, 13'h0000},
  '{13'h0000, 13'h0000, 13'h0300, 13'h0D00, 13'h0FFF, 13'h0000,
    13'h0000, 13'h0000, 13'h0000, 13'h0000, 13'h0000, 13'h0000},
  '{13'h0320, 13'h0410, 13'h0780, 13'h0A01, 13'h0C00, 13'h0D80,
    13'h0E55, 13'h0BFE, 13'h0000, 13'h0000, 13'h0000, 13'h0000},
  '{13'h0100, 13'h0280, 13'h0BE0, 13'h0F00, 13'h0000, 13'h0000,
    13'h0000, 13'h0000, 13'h0000, 13'h0000, 13'h0000, 13'h0000}
};

`endif

// ==== bench/matrix_log_tb.sv ====
`timescale 1ns/1ps
`include "matrix_log_settings.svh"

module matrix_log_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int STALL_CYCLES = 16;
  localparam int SIZE_W       = `MLOG_SIZE_W;

  `include "matrix_log_table.svh"

  ////////////////////////////////////////////////////////////////////////////
  // DUT signals with index 0 for channel A and index 1 for channel B
  ////////////////////////////////////////////////////////////////////////////

  logic                    CLK;
  logic                    RST;
  logic [1:0]              start;
  logic [1:0]              ready;
  logic [SIZE_W-1:0]       size_i [2];
  logic [SIZE_W-1:0]       size_j [2];
  logic [`MLOG_DATA_W-1:0] data_in [2];
  logic [1:0]              data_in_enable;
  logic [1:0]              in_ready;
  logic [`MLOG_RES_W-1:0]  data_out [2];
  logic [1:0]              out_enable;
  logic [1:0]              row_end;
  logic [1:0]              matrix_end;
  logic [1:0]              credit_return;

  // Consumer bookkeeping
  int outstanding [2] = '{0, 0};
  int seen [2] = '{0, 0};
  bit [1:0] hold = 2'b00;

  matrix_log_top dut (
    .CLK(CLK), .RST(RST),
    .start_a(start[0]), .ready_a(ready[0]),
    .size_i_a(size_i[0]), .size_j_a(size_j[0]),
    .data_in_a(data_in[0]), .data_in_enable_a(data_in_enable[0]),
    .in_ready_a(in_ready[0]), .data_out_a(data_out[0]), .out_enable_a(out_enable[0]),
    .row_end_a(row_end[0]), .matrix_end_a(matrix_end[0]),
    .credit_return_a(credit_return[0]),
    .start_b(start[1]), .ready_b(ready[1]),
    .size_i_b(size_i[1]), .size_j_b(size_j[1]),
    .data_in_b(data_in[1]), .data_in_enable_b(data_in_enable[1]),
    .in_ready_b(in_ready[1]), .data_out_b(data_out[1]), .out_enable_b(out_enable[1]),
    .row_end_b(row_end[1]), .matrix_end_b(matrix_end[1]),
    .credit_return_b(credit_return[1])
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  // Mitchell log2 by scaling with 256 and dropping the leading one
  function automatic logic [`MLOG_RES_W-1:0] mitchell_log2(input logic [`MLOG_DATA_W-1:0] x);
    int          msb;
    logic [31:0] wide;
    msb = -1;
    for (int b = 0; b < `MLOG_DATA_W; b++) begin
      if (x[b]) begin
        msb = b;
      end
    end
    if (msb < 0) begin
      return '0;
    end
    wide = {16'b0, x} << `MLOG_FRAC_W;
    wide = wide >> msb;
    return {msb[4:0], wide[`MLOG_FRAC_W-1:0]};
  endfunction

  function automatic int elems_for(input int ch);
    int sum;
    sum = 0;
    for (int r = 0; r < TBL_ROWS; r++) begin
      if (TBL_CHAN[r] == ch) begin
        sum += TBL_SIZE_I[r] * TBL_SIZE_J[r];
      end
    end
    return sum;
  endfunction

  // Expected column of the table against the model
  task automatic check_table();
    logic [`MLOG_RES_W-1:0] model;
    for (int r = 0; r < TBL_ROWS; r++) begin
      for (int k = 0; k < TBL_SIZE_I[r] * TBL_SIZE_J[r]; k++) begin
        model = mitchell_log2(TBL_DATA[r][k]);
        assert (model == TBL_EXP[r][k]) else begin
          $display("Error table row %0d element %0d: expected %h, actual %h",
                   r, k, model, TBL_EXP[r][k]);
          abort_run();
        end
      end
    end
  endtask

  // Nothing moves before the first start
  task automatic check_reset_state();
    repeat (3) begin
      assert (out_enable == 2'b00 && ready == 2'b00 && in_ready == 2'b00) else begin
        $display("Error after reset: a channel is busy before any start");
        abort_run();
      end
      @(negedge CLK);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-row stimulus and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic feed_row(input int ch, input int r);
    int n;
    n = TBL_SIZE_I[r] * TBL_SIZE_J[r];
    start[ch]  = 1'b1;
    size_i[ch] = SIZE_W'(TBL_SIZE_I[r]);
    size_j[ch] = SIZE_W'(TBL_SIZE_J[r]);
    @(negedge CLK);
    start[ch] = 1'b0;
    for (int k = 0; k < n; k++) begin
      // Random gap before each element
      repeat ($urandom % 3) @(negedge CLK);
      data_in[ch]        = TBL_DATA[r][k];
      data_in_enable[ch] = 1'b1;
      while (!in_ready[ch]) @(negedge CLK);
      @(negedge CLK);
      data_in_enable[ch] = 1'b0;
    end
  endtask

  // Channel parked on a result with every credit spent
  task automatic check_stall(input int ch);
    repeat (STALL_CYCLES) begin
      @(negedge CLK);
      assert (!out_enable[ch]) else begin
        $display("Error channel %0d sent a result with no credit left", ch);
        abort_run();
      end
    end
    assert (!in_ready[ch]) else begin
      $display("Error channel %0d takes input while its result waits for a credit", ch);
      abort_run();
    end
    hold[ch] = 1'b0;
  endtask

  task automatic collect_row(input int ch, input int r);
    int    n;
    int    cols;
    int    got;
    bit    last;
    bit    exp_row_end;
    string name;
    n    = TBL_SIZE_I[r] * TBL_SIZE_J[r];
    cols = TBL_SIZE_J[r];
    got  = 0;
    while (got < n) begin
      @(negedge CLK);
      if (out_enable[ch]) begin
        last        = (got == n - 1);
        exp_row_end = (got % cols == cols - 1);
        name = $sformatf("row %0d channel %0d element %0d", r, ch, got);
        assert (data_out[ch] == TBL_EXP[r][got]) else begin
          $display("Error %s data_out: expected %h, actual %h",
                   name, TBL_EXP[r][got], data_out[ch]);
          abort_run();
        end
        assert (row_end[ch] == exp_row_end) else begin
          $display("Error %s row_end: expected %b, actual %b", name, exp_row_end, row_end[ch]);
          abort_run();
        end
        assert (matrix_end[ch] == last && ready[ch] == last) else begin
          $display("Error %s matrix_end/ready: expected %b%b, actual %b%b",
                   name, last, last, matrix_end[ch], ready[ch]);
          abort_run();
        end
        got++;
        if (TBL_HOLD[r] && got == `MLOG_CREDITS) begin
          check_stall(ch);
        end
      end else begin
        // Markers and ready only travel with a result
        assert (!row_end[ch] && !matrix_end[ch] && !ready[ch]) else begin
          $display("Error channel %0d raised a marker or ready without a result", ch);
          abort_run();
        end
      end
    end
    // Back in IDLE and waiting for the next start
    @(negedge CLK);
    assert (!in_ready[ch] && !out_enable[ch]) else begin
      $display("Error channel %0d did not return to idle after row %0d", ch, r);
      abort_run();
    end
  endtask

  task automatic run_channel(input int ch);
    for (int r = 0; r < TBL_ROWS; r++) begin
      if (TBL_CHAN[r] == ch) begin
        // Full credit pool before a withheld run
        if (TBL_HOLD[r]) begin
          while (outstanding[ch] != 0) @(negedge CLK);
          hold[ch] = 1'b1;
        end
        fork
          feed_row(ch, r);
          collect_row(ch, r);
        join
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Processes
  ////////////////////////////////////////////////////////////////////////////

  // Consumer counts results and hands credits back at random
  initial begin : credit_source
    credit_return = 2'b00;
    forever begin
      @(negedge CLK);
      for (int ch = 0; ch < 2; ch++) begin
        if (out_enable[ch]) begin
          outstanding[ch]++;
          seen[ch]++;
        end
        if (!hold[ch] && outstanding[ch] > 0 && ($urandom % 2 == 0)) begin
          credit_return[ch] = 1'b1;
          outstanding[ch]--;
        end else begin
          credit_return[ch] = 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    #((((elems_for(0) + elems_for(1)) * 40) + RESET_CYCLES) * CLK_PERIOD);
    $display("Error watchdog expired before all results arrived");
    abort_run();
  end

  initial begin : main
    CLK            = 1'b0;
    RST            = 1'b1;
    start          = 2'b00;
    data_in_enable = 2'b00;
    for (int ch = 0; ch < 2; ch++) begin
      size_i[ch]  = '0;
      size_j[ch]  = '0;
      data_in[ch] = '0;
    end
    void'($urandom(1423));
    check_table();
    repeat (RESET_CYCLES) @(negedge CLK);
    RST = 1'b0;
    check_reset_state();
    // Both channels share the core from here on
    fork
      run_channel(0);
      run_channel(1);
    join
    repeat (4) @(negedge CLK);
    if (seen[0] == elems_for(0) && seen[1] == elems_for(1)) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Error total results: expected %0d/%0d, actual %0d/%0d",
               elems_for(0), elems_for(1), seen[0], seen[1]);
      abort_run();
    end
  end

endmodule

// ==== sim.f ====
+incdir+source
+incdir+bench
source/matrix_log_pkg.sv
source/log2_core.sv
source/core_arbiter.sv
source/matrix_log_channel.sv
source/matrix_log_top.sv
bench/matrix_log_tb.sv

// ==== Makefile ====
SOURCES := sim.f $(wildcard source/*.sv source/*.svh bench/*.sv bench/*.svh)

.PHONY: all run clean

all: obj_dir/Vmatrix_log_tb

obj_dir/Vmatrix_log_tb: $(SOURCES)
	verilator --binary --assert --top-module matrix_log_tb -f sim.f

run: obj_dir/Vmatrix_log_tb
	./obj_dir/Vmatrix_log_tb | tee sim.log
	@grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
